// File: common/cart_config.svh
`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////

`define CART_ADDR_W 24            // ROM byte address
`define CART_DATA_W 8             // One byte
`define CART_ROM_W 16             // External ROM data bus

////////////////////////////////////////////////////////////
// Timing
////////////////////////////////////////////////////////////

`define CART_FILTER_DEPTH 8       // Control shift register depth
`define CART_ROM_CYCLE_LEN 6      // MCU access length
`define CART_COP_CYCLE_LEN 16     // Coprocessor access length
`define CART_DEAD_TIMEOUT 64      // Short value for simulation
`define CART_TIMER_W 5            // Must hold the longest length

`endif

// File: common/cart_pkg.sv
`include "cart_config.svh"

package cart_pkg;

  // MCU byte request
  typedef struct packed {
    logic [`CART_ADDR_W-1:0] addr;
    logic                    write;
    logic [`CART_DATA_W-1:0] wdata;
  } mcu_req_t;

  // Coprocessor byte read request
  typedef struct packed {
    logic [`CART_ADDR_W-1:0] addr;
  } cop_req_t;

  typedef struct packed {
    logic [`CART_DATA_W-1:0] data;
  } rd_rsp_t;

  // External ROM controls, all active low
  typedef struct packed {
    logic [`CART_ADDR_W-2:0] addr;   // Word address
    logic                    we_n;
    logic                    bhe_n;
    logic                    ble_n;
    logic                    oe_n;
  } rom_bus_t;

  typedef enum logic [2:0] {IDLE, MCU_RD, MCU_WR, COP_RD, MCU_END, COP_END} access_kind_e;

endpackage

// File: common/snes_bus_pkg.sv
`include "cart_config.svh"

package snes_bus_pkg;

  // Raw pins, active low except cpu_clk
  typedef struct packed {
    logic read;
    logic write;
    logic romsel;
    logic cpu_clk;
  } snes_ctrl_t;

  // Filtered view of the SNES bus
  typedef struct packed {
    logic [`CART_ADDR_W-1:0] addr;
    logic                    read;
    logic                    write;
    logic                    romsel;
    logic                    cpu_clk;
  } snes_bus_t;

  typedef struct packed {
    logic cycle_start;   // CPU clock rising
    logic cycle_end;     // CPU clock falling
    logic rd_start;      // Read strobe falling
    logic dead;
  } snes_events_t;

endpackage

// File: design/snes_bus_monitor.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module snes_bus_monitor (
  input  logic                       CLK2,
  input  logic                       reset,
  input  logic [`CART_ADDR_W-1:0]    snes_addr,
  input  snes_bus_pkg::snes_ctrl_t   snes_ctrl,
  output snes_bus_pkg::snes_bus_t    bus,
  output snes_bus_pkg::snes_events_t events
);

  localparam int ADDR_STAGES = 7;
  localparam int DEAD_W = $clog2(`CART_DEAD_TIMEOUT + 1);

  logic [`CART_FILTER_DEPTH-1:0] read_sr;
  logic [`CART_FILTER_DEPTH-1:0] write_sr;
  logic [`CART_FILTER_DEPTH-1:0] romsel_sr;
  logic [`CART_FILTER_DEPTH-1:0] clk_sr;
  logic [`CART_ADDR_W-1:0]       addr_sr [ADDR_STAGES];
  logic [DEAD_W-1:0]             dead_cnt;
  logic                          dead_q;

  ////////////////////////////////////////////////////////////
  // Synchronizers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      read_sr   <= '1;   // Strobes idle high
      write_sr  <= '1;
      romsel_sr <= '1;
      clk_sr    <= '0;
    end else begin
      read_sr   <= {read_sr[`CART_FILTER_DEPTH-2:0], snes_ctrl.read};
      write_sr  <= {write_sr[`CART_FILTER_DEPTH-2:0], snes_ctrl.write};
      romsel_sr <= {romsel_sr[`CART_FILTER_DEPTH-2:0], snes_ctrl.romsel};
      clk_sr    <= {clk_sr[`CART_FILTER_DEPTH-2:0], snes_ctrl.cpu_clk};
    end
  end

  // Address settles later than the strobes
  always_ff @(posedge CLK2) begin
    addr_sr[0] <= snes_addr;
    for (int i = 1; i < ADDR_STAGES; i++) begin
      addr_sr[i] <= addr_sr[i-1];
    end
  end

  // Two adjacent taps must agree to pass a high level
  assign bus.addr    = addr_sr[ADDR_STAGES-1] & addr_sr[ADDR_STAGES-2];
  assign bus.read    = read_sr[2] & read_sr[1];
  assign bus.write   = write_sr[2] & write_sr[1];
  assign bus.romsel  = romsel_sr[2] & romsel_sr[1];
  assign bus.cpu_clk = clk_sr[2] & clk_sr[1];

  ////////////////////////////////////////////////////////////
  // Edge events
  ////////////////////////////////////////////////////////////

  assign events.cycle_start = ((clk_sr[7:2] & clk_sr[6:1]) == 6'b000011);
  assign events.cycle_end   = ((clk_sr[7:2] | clk_sr[6:1]) == 6'b111000);
  assign events.rd_start    = ((read_sr[7:2] | read_sr[6:1]) == 6'b111100);
  assign events.dead        = dead_q;

  // Dead watchdog on the filtered CPU clock
  always_ff @(posedge CLK2) begin
    if (reset) begin
      dead_cnt <= '0;
      dead_q   <= 1'b1;
    end else if (bus.cpu_clk) begin
      dead_cnt <= '0;
      dead_q   <= 1'b0;
    end else if (dead_cnt == DEAD_W'(`CART_DEAD_TIMEOUT)) begin
      dead_q <= 1'b1;    // Saturated, clock stopped
    end else begin
      dead_cnt <= dead_cnt + 1'b1;
    end
  end

  // SNES never reads and writes in the same bus cycle
  a_read_write_exclusive: assert property (@(posedge CLK2) disable iff (reset)
    bus.read || bus.write);

endmodule

// File: arbiter/request_slot.sv
`timescale 1ns/1ps

module request_slot #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     CLK2,
  input  logic     reset,
  input  logic     in_valid,
  input  payload_t in_payload,
  input  logic     done,
  output logic     in_ready,
  output logic     pending,
  output payload_t held
);

  // Accept only when empty
  assign in_ready = ~pending;

  always_ff @(posedge CLK2) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (in_valid && in_ready) begin
      pending <= 1'b1;
    end else if (done) begin
      pending <= 1'b0;   // Ready again next cycle
    end
  end

  // Payload holds its value until the next handshake
  always_ff @(posedge CLK2) begin
    if (in_valid && in_ready) begin
      held <= in_payload;
    end
  end

  // FSM finishes only requests that were actually captured
  a_done_needs_pending: assert property (@(posedge CLK2) disable iff (reset)
    done |-> pending);

endmodule

// File: arbiter/access_timer.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module access_timer (
  input  logic                     CLK2,
  input  logic                     reset,
  input  logic                     load,
  input  logic [`CART_TIMER_W-1:0] length,
  output logic                     expired
);

  logic [`CART_TIMER_W-1:0] count;

  always_ff @(posedge CLK2) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= length;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign expired = (count == '0) && !load;

  // A new access only starts once the previous one has run out
  a_no_load_while_running: assert property (@(posedge CLK2) disable iff (reset)
    load |-> (count == '0));

endmodule

// File: arbiter/rom_arbiter_fsm.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module rom_arbiter_fsm (
  input  logic                       CLK2,
  input  logic                       reset,
  input  snes_bus_pkg::snes_events_t events,
  input  snes_bus_pkg::snes_bus_t    bus,
  input  logic                       mcu_pending,
  input  logic                       mcu_write,
  input  logic                       cop_pending,
  input  logic                       expired,
  output cart_pkg::access_kind_e     state,
  output logic                       timer_load,
  output logic [`CART_TIMER_W-1:0]   timer_length,
  output logic                       mcu_done,
  output logic                       cop_done
);

  import cart_pkg::*;

  access_kind_e state_next;
  logic         free_strobe;
  logic         free_slot;
  logic         revive;
  logic         in_access;
  logic         wait_timer;

  // Non-ROM cycle leaves the bus free right after it starts
  always_ff @(posedge CLK2) begin
    if (reset) free_strobe <= 1'b0;
    else free_strobe <= events.cycle_start & bus.romsel;
  end

  assign free_slot = events.cycle_end | free_strobe;
  assign revive    = events.dead & bus.cpu_clk;
  assign in_access = (state == MCU_RD) || (state == MCU_WR) || (state == COP_RD);

  // After an abort the timer may still be counting
  always_ff @(posedge CLK2) begin
    if (reset) wait_timer <= 1'b0;
    else if (revive && in_access) wait_timer <= 1'b1;
    else if (expired) wait_timer <= 1'b0;
  end

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_next   = state;
    timer_load   = 1'b0;
    timer_length = '0;
    if (revive) begin
      state_next = IDLE;   // SNES back, drop and retry later
    end else begin
      case (state)
        IDLE: begin
          if (wait_timer) begin
            state_next = IDLE;
          end else if (cop_pending) begin
            state_next   = COP_RD;   // Coprocessor never waits for a slot
            timer_load   = 1'b1;
            timer_length = `CART_TIMER_W'(`CART_COP_CYCLE_LEN);
          end else if (mcu_pending && (free_slot || events.dead)) begin
            state_next   = mcu_write ? MCU_WR : MCU_RD;
            timer_load   = 1'b1;
            timer_length = `CART_TIMER_W'(`CART_ROM_CYCLE_LEN);
          end
        end
        MCU_RD, MCU_WR: if (expired) state_next = MCU_END;
        COP_RD: if (expired) state_next = COP_END;
        default: state_next = IDLE;   // END states last one cycle
      endcase
    end
  end

  always_ff @(posedge CLK2) begin
    if (reset) state <= IDLE;
    else state <= state_next;
  end

  assign mcu_done = (state == MCU_END);
  assign cop_done = (state == COP_END);

endmodule

// File: design/rom_port.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module rom_port (
  input  logic                     CLK2,
  input  logic                     reset,
  input  cart_pkg::access_kind_e   state,
  input  snes_bus_pkg::snes_bus_t  bus,
  input  cart_pkg::mcu_req_t       mcu_held,
  input  cart_pkg::cop_req_t       cop_held,
  input  logic [`CART_ADDR_W-1:0]  rom_mask,
  input  logic [`CART_ROM_W-1:0]   rom_din,
  output cart_pkg::rom_bus_t       rom,
  output logic [`CART_ROM_W-1:0]   rom_dout,
  output logic                     rom_dout_en,
  output cart_pkg::rd_rsp_t        mcu_rsp,
  output cart_pkg::rd_rsp_t        cop_rsp,
  output logic [`CART_DATA_W-1:0]  snes_data_out,
  output logic                     snes_data_oe
);

  import cart_pkg::*;

  logic [`CART_ADDR_W-1:0] snes_rom_addr;
  logic [`CART_ADDR_W-1:0] byte_addr;
  logic [`CART_DATA_W-1:0] rd_byte;
  logic                    mcu_access;
  logic                    cop_access;
  logic                    lane_lo;

  assign mcu_access    = (state == MCU_RD) || (state == MCU_WR);
  assign cop_access    = (state == COP_RD);
  assign snes_rom_addr = bus.addr & rom_mask;

  // SNES owns the address whenever no access runs
  assign byte_addr = mcu_access ? mcu_held.addr :
                     cop_access ? cop_held.addr : snes_rom_addr;

  assign lane_lo = byte_addr[0];   // Odd byte sits on the low lane
  assign rd_byte = lane_lo ? rom_din[`CART_DATA_W-1:0] : rom_din[`CART_ROM_W-1:`CART_DATA_W];

  ////////////////////////////////////////////////////////////
  // ROM bus
  ////////////////////////////////////////////////////////////

  assign rom.addr  = byte_addr[`CART_ADDR_W-1:1];
  assign rom.we_n  = (state != MCU_WR);
  assign rom.oe_n  = (state == MCU_WR);
  assign rom.bhe_n = lane_lo;
  assign rom.ble_n = ~lane_lo;

  assign rom_dout_en = (state == MCU_WR);
  assign rom_dout    = lane_lo ? {{`CART_DATA_W{1'b0}}, mcu_held.wdata}
                               : {mcu_held.wdata, {`CART_DATA_W{1'b0}}};

  // Last cycle of the access leaves the settled byte
  always_ff @(posedge CLK2) begin
    if (state == MCU_RD) mcu_rsp.data <= rd_byte;
    if (cop_access) cop_rsp.data <= rd_byte;
  end

  // SNES read data, registered toward the pins
  always_ff @(posedge CLK2) begin
    if (reset) snes_data_oe <= 1'b1;
    else snes_data_oe <= bus.read | bus.romsel;
  end

  always_ff @(posedge CLK2) begin
    if (!mcu_access && !cop_access) snes_data_out <= rd_byte;   // Hold during accesses
  end

endmodule

// File: design/cart_top.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module cart_top (
  input  logic                      CLK2,
  input  logic                      reset,
  // SNES
  input  logic [`CART_ADDR_W-1:0]   snes_addr,
  input  snes_bus_pkg::snes_ctrl_t  snes_ctrl,
  output logic [`CART_DATA_W-1:0]   snes_data_out,
  output logic                      snes_data_oe,
  // MCU
  input  logic                      mcu_req_valid,
  input  cart_pkg::mcu_req_t        mcu_req,
  output logic                      mcu_req_ready,
  output cart_pkg::rd_rsp_t         mcu_rsp,
  output logic                      mcu_rsp_valid,
  // Coprocessor
  input  logic                      cop_req_valid,
  input  cart_pkg::cop_req_t        cop_req,
  output logic                      cop_req_ready,
  output cart_pkg::rd_rsp_t         cop_rsp,
  output logic                      cop_rsp_valid,
  // ROM
  output cart_pkg::rom_bus_t        rom,
  output logic [`CART_ROM_W-1:0]    rom_dout,
  output logic                      rom_dout_en,
  input  logic [`CART_ROM_W-1:0]    rom_din,
  input  logic [`CART_ADDR_W-1:0]   rom_mask
);

  import cart_pkg::*;
  import snes_bus_pkg::*;

  snes_bus_t                bus;
  snes_events_t             events;
  mcu_req_t                 mcu_held;
  cop_req_t                 cop_held;
  access_kind_e             state;
  logic                     mcu_pending;
  logic                     cop_pending;
  logic                     mcu_done;
  logic                     cop_done;
  logic                     timer_load;
  logic [`CART_TIMER_W-1:0] timer_length;
  logic                     expired;

  snes_bus_monitor monitor0 (.CLK2, .reset, .snes_addr, .snes_ctrl, .bus, .events);

  request_slot #(.payload_t(mcu_req_t)) mcu_slot0 (
    .CLK2, .reset, .in_valid(mcu_req_valid), .in_payload(mcu_req), .done(mcu_done),
    .in_ready(mcu_req_ready), .pending(mcu_pending), .held(mcu_held));

  request_slot #(.payload_t(cop_req_t)) cop_slot0 (
    .CLK2, .reset, .in_valid(cop_req_valid), .in_payload(cop_req), .done(cop_done),
    .in_ready(cop_req_ready), .pending(cop_pending), .held(cop_held));

  access_timer timer0 (.CLK2, .reset, .load(timer_load), .length(timer_length), .expired);

  rom_arbiter_fsm fsm0 (
    .CLK2, .reset, .events, .bus, .mcu_pending, .mcu_write(mcu_held.write),
    .cop_pending, .expired, .state, .timer_load, .timer_length, .mcu_done, .cop_done);

  rom_port port0 (
    .CLK2, .reset, .state, .bus, .mcu_held, .cop_held, .rom_mask, .rom_din,
    .rom, .rom_dout, .rom_dout_en, .mcu_rsp, .cop_rsp, .snes_data_out, .snes_data_oe);

  // Writes complete through ready only
  assign mcu_rsp_valid = mcu_done & ~mcu_held.write;
  assign cop_rsp_valid = cop_done;

endmodule

// File: bench/tb_cart.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module tb_cart;

  import cart_pkg::*;
  import snes_bus_pkg::*;

  localparam int TIMEOUT = 400;     // Cycles allowed for any one wait
  localparam int SNES_HALF = 8;     // Bench cycles per CPU clock phase
  localparam int ADDR_SETTLE = 8;   // Address filter lag plus margin

  logic                    CLK2 = 1'b0;
  logic                    reset;
  logic [`CART_ADDR_W-1:0] snes_addr;
  snes_ctrl_t              snes_ctrl;
  logic                    snes_read;
  logic                    snes_write;
  logic                    snes_romsel;
  logic                    snes_cpu_clk = 1'b0;
  logic                    snes_clk_run;
  int                      clk_phase = 0;
  logic [`CART_DATA_W-1:0] snes_data_out;
  logic                    snes_data_oe;
  logic                    mcu_req_valid;
  mcu_req_t                mcu_req;
  logic                    mcu_req_ready;
  rd_rsp_t                 mcu_rsp;
  logic                    mcu_rsp_valid;
  logic                    cop_req_valid;
  cop_req_t                cop_req;
  logic                    cop_req_ready;
  rd_rsp_t                 cop_rsp;
  logic                    cop_rsp_valid;
  rom_bus_t                rom;
  logic [`CART_ROM_W-1:0]  rom_dout;
  logic                    rom_dout_en;
  logic [`CART_ROM_W-1:0]  rom_din;
  logic [`CART_ADDR_W-1:0] rom_mask;
  logic [`CART_ROM_W-1:0]  rom_mem [65536];

  assign snes_ctrl = {snes_read, snes_write, snes_romsel, snes_cpu_clk};

  cart_top dut0 (
    .CLK2, .reset, .snes_addr, .snes_ctrl, .snes_data_out, .snes_data_oe,
    .mcu_req_valid, .mcu_req, .mcu_req_ready, .mcu_rsp, .mcu_rsp_valid,
    .cop_req_valid, .cop_req, .cop_req_ready, .cop_rsp, .cop_rsp_valid,
    .rom, .rom_dout, .rom_dout_en, .rom_din, .rom_mask);

  ////////////////////////////////////////////////////////////
  // Clock, ROM model and SNES CPU clock
  ////////////////////////////////////////////////////////////

  initial begin
    forever #20 CLK2 = ~CLK2;
  end

  initial begin
    for (int i = 0; i < 65536; i++) begin
      rom_mem[i] = 16'(i * 40503 + (i >>> 7));   // Odd multiplier, every word differs
    end
  end

  assign rom_din = rom_mem[rom.addr[15:0]];   // Asynchronous read

  always @(posedge CLK2) begin
    if (!rom.we_n) begin
      if (!rom.bhe_n) rom_mem[rom.addr[15:0]][15:8] = rom_dout[15:8];
      if (!rom.ble_n) rom_mem[rom.addr[15:0]][7:0] = rom_dout[7:0];
    end
  end

  // Data bus driven only by writes, ROM output on otherwise
  always @(negedge CLK2) begin
    if (!reset) begin
      check_cond(rom_dout_en == !rom.we_n,
                 "rom_bus: data drive enable does not follow the write enable");
      check_cond(rom.oe_n == !rom.we_n,
                 "rom_bus: ROM output enable does not follow the write enable");
    end
  end

  // Square wave while running, held low otherwise
  always @(negedge CLK2) begin
    if (!snes_clk_run) begin
      clk_phase    = 0;
      snes_cpu_clk = 1'b0;
    end else if (clk_phase == SNES_HALF - 1) begin
      clk_phase    = 0;
      snes_cpu_clk = ~snes_cpu_clk;
    end else begin
      clk_phase = clk_phase + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [7:0] model_byte(input logic [`CART_ADDR_W-1:0] addr);
    logic [15:0] word;
    word = rom_mem[addr[16:1]];
    return addr[0] ? word[7:0] : word[15:8];   // Odd byte on the low lane
  endfunction

  function automatic mcu_req_t make_req(input logic [`CART_ADDR_W-1:0] addr,
                                        input logic write, input logic [7:0] wdata);
    mcu_req_t req;
    req.addr  = addr;
    req.write = write;
    req.wdata = wdata;
    return req;
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_byte(input string test, input logic [7:0] expected,
                            input logic [7:0] actual);
    assert (actual == expected) else begin
      $display("MISMATCH %s expected %h actual %h", test, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_cond(input logic cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      abort_run();
    end
  endtask

  // Holds valid until ready, then one transfer edge
  task automatic offer_mcu(input string test, input mcu_req_t req);
    int n;
    n = 0;
    mcu_req_valid = 1'b1;
    mcu_req       = req;
    while (!mcu_req_ready && n < TIMEOUT) begin
      @(negedge CLK2);
      n++;
    end
    check_cond(mcu_req_ready, {test, ": MCU request was never accepted"});
    @(posedge CLK2);
    @(negedge CLK2);
    mcu_req_valid = 1'b0;
  endtask

  task automatic wait_mcu_rsp(input string test, output logic [7:0] data);
    int n;
    n = 0;
    while (!mcu_rsp_valid && n < TIMEOUT) begin
      @(negedge CLK2);
      n++;
    end
    check_cond(mcu_rsp_valid, {test, ": no MCU read response arrived"});
    data = mcu_rsp.data;
    @(negedge CLK2);
  endtask

  task automatic wait_mcu_ready(input string test);
    int n;
    n = 0;
    while (!mcu_req_ready && n < TIMEOUT) begin
      @(negedge CLK2);
      n++;
    end
    check_cond(mcu_req_ready, {test, ": MCU write never completed"});
  endtask

  task automatic mcu_write(input string test, input logic [`CART_ADDR_W-1:0] addr,
                           input logic [7:0] data);
    offer_mcu(test, make_req(addr, 1'b1, data));
    wait_mcu_ready(test);
  endtask

  task automatic mcu_read(input string test, input logic [`CART_ADDR_W-1:0] addr,
                          output logic [7:0] data);
    offer_mcu(test, make_req(addr, 1'b0, 8'h00));
    wait_mcu_rsp(test, data);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic reset_state();
    check_cond(mcu_req_ready && cop_req_ready, "reset_state: a request ready is low");
    check_cond(rom.we_n, "reset_state: ROM write enable is active");
    check_cond(snes_data_oe, "reset_state: SNES data output is enabled");
    repeat (10) begin   // Quiet window
      @(negedge CLK2);
      check_cond(!mcu_rsp_valid && !cop_rsp_valid, "reset_state: a response valid was seen");
    end
  endtask

  task automatic dead_write_read();
    logic [`CART_ADDR_W-1:0] addrs [6];
    logic [7:0]              data [6];
    logic [7:0]              other;
    logic [7:0]              got;
    for (int i = 0; i < 6; i++) begin
      addrs[i] = {7'd0, 12'($urandom), 4'(i), i[0]};   // Distinct words, both lanes
      data[i]  = 8'($urandom);
      other    = model_byte(addrs[i] ^ 24'd1);
      mcu_write("dead_write", addrs[i], data[i]);
      check_byte("dead_write", data[i], model_byte(addrs[i]));
      check_byte("dead_write_other_lane", other, model_byte(addrs[i] ^ 24'd1));
    end
    for (int i = 0; i < 6; i++) begin
      mcu_read("dead_read", addrs[i], got);
      check_byte("dead_read", data[i], got);
    end
  endtask

  task automatic alive_reads();
    logic [`CART_ADDR_W-1:0] addr;
    logic [7:0]              got;
    snes_clk_run = 1'b1;   // romsel stays high, so every cycle is non-ROM
    repeat (4 * SNES_HALF) @(negedge CLK2);
    for (int i = 0; i < 4; i++) begin
      addr = {7'd0, 17'($urandom)};
      mcu_read("alive_read", addr, got);
      check_byte("alive_read", model_byte(addr), got);
    end
  endtask

  task automatic cop_priority();
    logic [`CART_ADDR_W-1:0] cop_addr;
    logic [`CART_ADDR_W-1:0] mcu_addr;
    logic [7:0]              cop_data;
    logic [7:0]              mcu_data;
    logic                    got_cop;
    logic                    got_mcu;
    logic                    cop_first;
    int                      n;
    cop_addr  = {7'd0, 17'($urandom)};
    mcu_addr  = {7'd0, 17'($urandom)};
    got_cop   = 1'b0;
    got_mcu   = 1'b0;
    cop_first = 1'b0;
    n         = 0;
    check_cond(mcu_req_ready && cop_req_ready, "cop_priority: a slot is still full");
    mcu_req_valid = 1'b1;
    mcu_req       = make_req(mcu_addr, 1'b0, 8'h00);
    cop_req_valid = 1'b1;
    cop_req.addr  = cop_addr;
    @(posedge CLK2);   // Both slots capture here
    @(negedge CLK2);
    mcu_req_valid = 1'b0;
    cop_req_valid = 1'b0;
    while (!(got_cop && got_mcu) && n < TIMEOUT) begin
      if (cop_rsp_valid) begin
        got_cop   = 1'b1;
        cop_data  = cop_rsp.data;
        cop_first = !got_mcu && !mcu_rsp_valid;
      end
      if (mcu_rsp_valid) begin
        got_mcu  = 1'b1;
        mcu_data = mcu_rsp.data;
      end
      @(negedge CLK2);
      n++;
    end
    check_cond(got_cop && got_mcu, "cop_priority: timed out waiting for both responses");
    check_cond(cop_first, "cop_priority: MCU response came before the coprocessor response");
    check_byte("cop_priority_cop", model_byte(cop_addr), cop_data);
    check_byte("cop_priority_mcu", model_byte(mcu_addr), mcu_data);
    snes_clk_run = 1'b0;
  endtask

  task automatic snes_read_path();
    logic [`CART_ADDR_W-1:0] addr;
    logic [`CART_ADDR_W-1:0] mask;
    int                      n;
    mask      = 24'($urandom);
    addr      = 24'($urandom);
    n         = 0;
    rom_mask  = mask;
    snes_addr = addr;
    repeat (ADDR_SETTLE) @(negedge CLK2);   // Address is set up before the strobes
    check_cond(snes_data_oe, "snes_read: data output enabled before the read strobe");
    snes_read   = 1'b0;
    snes_romsel = 1'b0;
    while (snes_data_oe && n < TIMEOUT) begin
      @(negedge CLK2);
      n++;
    end
    check_cond(!snes_data_oe, "snes_read: data output was never enabled");
    check_byte("snes_read", model_byte(addr & mask), snes_data_out);
    snes_read   = 1'b1;
    snes_romsel = 1'b1;
    n = 0;
    while (!snes_data_oe && n < TIMEOUT) begin
      @(negedge CLK2);
      n++;
    end
    check_cond(snes_data_oe, "snes_read: data output stayed enabled after the read");
  endtask

  task automatic back_pressure();
    logic [`CART_ADDR_W-1:0] addr_a;
    logic [`CART_ADDR_W-1:0] addr_b;
    logic [7:0]              data_a;
    logic [7:0]              data_b;
    logic                    first_seen;
    int                      n;
    addr_a     = {7'd0, 17'($urandom)};
    addr_b     = {7'd0, 17'($urandom)};
    first_seen = 1'b0;
    n          = 0;
    offer_mcu("back_pressure_first", make_req(addr_a, 1'b0, 8'h00));
    check_cond(!mcu_req_ready, "back_pressure: ready high while the first request is held");
    mcu_req_valid = 1'b1;   // Second request waits with valid high
    mcu_req       = make_req(addr_b, 1'b0, 8'h00);
    while (!mcu_req_ready && n < TIMEOUT) begin
      @(negedge CLK2);
      n++;
      if (mcu_rsp_valid) begin
        first_seen = 1'b1;
        data_a     = mcu_rsp.data;
      end
    end
    check_cond(mcu_req_ready, "back_pressure: ready never returned for the second request");
    check_cond(first_seen, "back_pressure: second request accepted before the first finished");
    @(posedge CLK2);
    @(negedge CLK2);
    mcu_req_valid = 1'b0;
    wait_mcu_rsp("back_pressure_second", data_b);
    check_byte("back_pressure_first", model_byte(addr_a), data_a);
    check_byte("back_pressure_second", model_byte(addr_b), data_b);
  endtask

  initial begin
    void'($urandom(32'h5940));
    reset         = 1'b1;
    snes_addr     = '0;
    snes_read     = 1'b1;
    snes_write    = 1'b1;
    snes_romsel   = 1'b1;
    snes_clk_run  = 1'b0;
    mcu_req_valid = 1'b0;
    mcu_req       = '0;
    cop_req_valid = 1'b0;
    cop_req       = '0;
    rom_mask      = '1;
    repeat (3) @(negedge CLK2);
    reset = 1'b0;
    reset_state();
    dead_write_read();
    alive_reads();
    cop_priority();
    snes_read_path();
    back_pressure();
    $display("Test passed");
    $finish;
  end

endmodule

// File: compile.f
+incdir+common
common/cart_pkg.sv
common/snes_bus_pkg.sv
design/snes_bus_monitor.sv
arbiter/request_slot.sv
arbiter/access_timer.sv
arbiter/rom_arbiter_fsm.sv
design/rom_port.sv
design/cart_top.sv
bench/tb_cart.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then scan the log for the failure line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module tb_cart -o sim_cart \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_cart > sim.log 2>&1 || true
cat sim.log
! grep -q "Test failed" sim.log && grep -q "Test passed" sim.log
